//--- common/cryptPkg.sv
// shared definitions for the fetch decryption unit
// key stream sizes, checksum constants, round count
// APB register offsets and FSM states
// fetch request/response and key info structs

package cryptPkg;

    localparam int keyBytes = 20;                 // bytes in one key stream
    localparam int rawWidth = 160;                // raw key register width
    localparam int numRounds = 4;                 // feistel rounds per word

    localparam logic [7:0]  sumMask = 8'hCF;      // byte bits that trigger the xor
    localparam logic [11:0] sumXor  = 12'h065;    // xor applied to running sum

    // APB register map, byte offsets
    typedef enum logic [3:0] {
        regKeyData = 4'h0,                        // key byte strobe
        regExpSum  = 4'h4,                        // expected checksum
        regStatus  = 4'h8,                        // read only status
        regCtrl    = 4'hC                         // reload control
    } apbRegT;

    typedef enum logic [2:0] {
        sIdle,                                    // waiting for first key byte
        sLoad,                                    // key bytes arriving
        sCheck,                                   // compare checksum
        sReady,                                   // accepting fetches
        sBusy,                                    // word in flight
        sFault                                    // checksum mismatch, locked
    } cryptStateT;

    typedef struct packed {
        logic        valid;
        logic [23:0] addr;                        // word address
        logic [15:0] data;
    } fetchReqT;

    typedef struct packed {
        logic        valid;
        logic [15:0] data;
        logic        crypted;                     // low when address bypassed
    } fetchRspT;

    typedef struct packed {
        logic [63:0] key;                         // cipher key, byte k = round key k
        logic [15:0] addrLimit;                   // highest decrypted address page
        logic [11:0] sum;                         // running checksum
        logic [4:0]  count;                       // bytes loaded, saturating
        logic        ok;                          // full load and sum matches
    } keyInfoT;

endpackage

//--- keyload/keyLoad.sv
// key stream loader
// byte shift register with running checksum
// key and address limit extraction, ok flag

`timescale 1ns/1ps

module keyLoad import cryptPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  byteIn,
    input  logic        byteWe,
    input  logic        reload,
    input  logic [11:0] expSum,
    output keyInfoT     keyInfo
);

    logic                lastWe;              // strobe edge detect
    logic                strobe;
    logic [rawWidth-1:0] raw;
    logic [11:0]         sum;
    logic [4:0]          count;
    logic [11:0]         sumMix;              // sum after conditional xor
    logic [63:0]         key;
    logic [15:0]         addrLimit;
    logic                sumOk;

    assign strobe = byteWe && !lastWe;        // one shift per write strobe
    assign sumMix = ((byteIn & sumMask) != 8'd0) ? (sum ^ sumXor) : sum;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lastWe <= 1'b0;
            raw    <= '0;
            sum    <= 12'd0;
            count  <= 5'd0;
        end else begin
            lastWe <= byteWe;
            if (reload) begin                 // host restarts the stream
                raw   <= '0;
                sum   <= 12'd0;
                count <= 5'd0;
            end else if (strobe) begin
                raw <= {byteIn, raw[rawWidth-1:8]};   // new byte on top
                sum <= sumMix + {4'd0, byteIn};       // wraps at 4096
                if (count != 5'(keyBytes))
                    count <= count + 5'd1;            // saturate at full stream
            end
        end
    end

    // last byte written becomes key byte 0
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            key[8*k +: 8] = raw[8*(keyBytes-1-k) +: 8];
        end
    end

    // first stream byte is the high half of the limit
    assign addrLimit = {raw[7:0], raw[15:8]};
    assign sumOk     = (count == 5'(keyBytes)) && (sum == expSum);

    assign keyInfo = '{
        key:       key,
        addrLimit: addrLimit,
        sum:       sum,
        count:     count,
        ok:        sumOk
    };

    // byte counter saturates and never runs past a full stream
    countBound: assert property (
        @(posedge clk) disable iff (rst)
        (count == 5'(keyBytes)) |=> (count == 5'(keyBytes)) || $past(reload)
    ) else $error("keyLoad count left full stream without reload: %0d", count);

endmodule

//--- hdl/apbRegs.sv
// APB3 slave for the decryption unit
// key byte strobe, expected checksum, reload control
// status word with loader and FSM state

`timescale 1ns/1ps

module apbRegs import cryptPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [7:0]  byteIn,
    output logic        byteWe,
    output logic        reload,
    output logic [11:0] expSum,
    input  keyInfoT     keyInfo,
    input  cryptStateT  state
);

    logic        access;                      // access phase of a transfer
    logic        expWe;
    logic        fsmReady;
    logic        fsmFault;
    logic [31:0] status;

    assign access   = psel && penable;
    assign pready   = 1'b1;                   // no wait states
    assign byteIn   = pwdata[7:0];            // only the low byte is loaded
    assign fsmReady = (state == sReady);
    assign fsmFault = (state == sFault);

    // sum 11:0, count 20:16, ok 24, ready 25, fault 26
    assign status = {5'd0, fsmFault, fsmReady, keyInfo.ok, 3'd0,
                     keyInfo.count, 4'd0, keyInfo.sum};

    always_comb begin
        prdata  = 32'd0;
        pslverr = 1'b0;
        byteWe  = 1'b0;
        reload  = 1'b0;
        expWe   = 1'b0;
        case (apbRegT'(paddr))
            regKeyData: byteWe = access && pwrite;
            regExpSum: begin
                expWe  = access && pwrite;
                prdata = {20'd0, expSum};
            end
            regStatus: begin
                prdata  = status;
                pslverr = access && pwrite;   // status is read only
            end
            regCtrl:    reload = access && pwrite && pwdata[0];
            default:    pslverr = access;     // unmapped offset
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            expSum <= 12'd0;
        end else if (expWe) begin
            expSum <= pwdata[11:0];
        end
    end

endmodule

//--- hdl/cryptFsm.sv
// decryption unit sequencer
// load, checksum check, ready, busy and fault states
// capture and round counter start for accepted fetches

`timescale 1ns/1ps

module cryptFsm import cryptPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  keyInfoT    keyInfo,
    input  logic       byteWe,
    input  logic       reload,
    input  logic       reqValid,
    input  logic       lastRound,
    output logic       start,
    output logic       capture,
    output logic       fetchReady,
    output cryptStateT state
);

    cryptStateT stateNext;
    logic       startQ;                       // rounds begin after capture cycle

    assign fetchReady = (state == sReady);
    assign capture    = fetchReady && reqValid;   // requests ignored unless ready
    assign start      = startQ;

    always_comb begin
        stateNext = state;
        case (state)
            sIdle:   if (byteWe) stateNext = sLoad;
            sLoad:   if (keyInfo.count == 5'(keyBytes)) stateNext = sCheck;
            sCheck:  stateNext = keyInfo.ok ? sReady : sFault;
            sReady:  if (capture) stateNext = sBusy;
            sBusy:   if (lastRound) stateNext = sReady;
            sFault:  stateNext = sFault;      // stays until reload
            default: stateNext = sIdle;
        endcase
        // a word in flight always finishes before a reload takes hold
        if (reload && state != sBusy)
            stateNext = sIdle;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= sIdle;
            startQ <= 1'b0;
        end else begin
            state  <= stateNext;
            startQ <= capture;
        end
    end

    // busy ends on the counter's last round, one capture cycle plus four rounds on
    busyExit: assert property (
        @(posedge clk) disable iff (rst)
        capture |-> ##5 (state == sBusy && lastRound)
    ) else $error("cryptFsm busy window did not end on lastRound after four rounds");

endmodule

//--- hdl/roundCounter.sv
// feistel round counter
// counts rounds 0..3 after start, flags the last one

`timescale 1ns/1ps

module roundCounter import cryptPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    output logic       lastRound,
    output logic [1:0] round
);

    logic active;                             // rounds in progress

    assign lastRound = active && (round == 2'(numRounds - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            round  <= 2'd0;
        end else if (start) begin
            active <= 1'b1;
            round  <= 2'd0;
        end else if (active) begin
            active <= !lastRound;             // idle after round 3
            round  <= lastRound ? 2'd0 : round + 2'd1;
        end
    end

endmodule

//--- cipher/feistelCore.sv
// iterative feistel datapath for 16-bit program words
// one round per cycle, key bytes picked by round index
// address range bypass and registered response

`timescale 1ns/1ps

module feistelCore import cryptPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        capture,
    input  fetchReqT    req,
    input  logic [63:0] key,
    input  logic [15:0] addrLimit,
    input  logic [1:0]  round,
    input  logic        lastRound,
    output fetchRspT    rsp
);

    logic [7:0]  left;                        // high byte half
    logic [7:0]  right;                       // low byte half
    logic [7:0]  addrByte;                    // tweak from low address byte
    logic        bypass;                      // above limit, pass through
    logic        primed;                      // capture cycle marker
    logic        active;                      // rounds running
    logic [7:0]  keyA;
    logic [7:0]  keyB;
    logic [7:0]  mixIn;
    logic [7:0]  fOut;
    logic        rspValid;
    logic [15:0] rspData;
    logic        rspCrypted;

    // round i uses key bytes 2i and 2i+1
    assign keyA  = key[{round, 4'd0} +: 8];
    assign keyB  = key[{round, 4'd8} +: 8];
    assign mixIn = right ^ keyA;
    assign fOut  = ({mixIn[6:0], mixIn[7]} + keyB) ^ addrByte;   // rotl1, add, tweak

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            primed   <= 1'b0;
            active   <= 1'b0;
            rspValid <= 1'b0;
        end else begin
            primed   <= capture;
            if (primed)
                active <= 1'b1;
            else if (lastRound)
                active <= 1'b0;
            rspValid <= active && lastRound;  // single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            left     <= req.data[15:8];
            right    <= req.data[7:0];
            addrByte <= req.addr[7:0];
            bypass   <= (req.addr[23:8] > addrLimit);
        end else if (active && !bypass) begin
            left  <= right;
            right <= left ^ fOut;
        end
        if (active && lastRound) begin
            // final swap folded in, left ends up on top
            rspData    <= bypass ? {left, right} : {right, left ^ fOut};
            rspCrypted <= !bypass;
        end
    end

    assign rsp = '{valid: rspValid, data: rspData, crypted: rspCrypted};

    // response is a pulse, never held
    rspPulse: assert property (
        @(posedge clk) disable iff (rst)
        rspValid |=> !rspValid
    ) else $error("feistelCore response valid held for two cycles");

    // counter and datapath stay in step
    roundSync: assert property (
        @(posedge clk) disable iff (rst)
        lastRound |-> active
    ) else $error("feistelCore saw lastRound while idle");

endmodule

//--- hdl/cryptTop.sv
// top level of the fetch decryption unit
// APB registers, key loader, FSM, round counter, feistel core

`timescale 1ns/1ps

module cryptTop import cryptPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  fetchReqT    fetchReq,
    output fetchRspT    fetchRsp,
    output logic        fetchReady
);

    logic [7:0]  byteIn;
    logic        byteWe;
    logic        reload;
    logic [11:0] expSum;
    keyInfoT     keyInfo;
    cryptStateT  state;
    logic        start;
    logic        capture;
    logic        lastRound;
    logic [1:0]  round;

    apbRegs uApb (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .byteIn, .byteWe, .reload, .expSum, .keyInfo, .state
    );

    keyLoad uKey (
        .clk, .rst, .byteIn, .byteWe, .reload, .expSum, .keyInfo
    );

    cryptFsm uFsm (
        .clk, .rst, .keyInfo, .byteWe, .reload,
        .reqValid (fetchReq.valid),
        .lastRound, .start, .capture, .fetchReady, .state
    );

    roundCounter uRound (
        .clk, .rst, .start, .lastRound, .round
    );

    feistelCore uCore (
        .clk, .rst, .capture,
        .req       (fetchReq),
        .key       (keyInfo.key),
        .addrLimit (keyInfo.addrLimit),
        .round, .lastRound,
        .rsp       (fetchRsp)
    );

    // counter only moves while a word is in flight
    countInBusy: assert property (
        @(posedge clk) disable iff (rst)
        (round != 2'd0 || lastRound) |-> (state == sBusy)
    ) else $error("round counter active in state %s", state.name());

endmodule

//--- sim/cryptModel.svh
// reference model for the fetch decryption unit
// LCG step, checksum step, key extraction, cipher word
// APB error decode and status word layout

`ifndef CRYPT_MODEL_SVH
`define CRYPT_MODEL_SVH

function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;    // classic LCG constants
endfunction

function automatic logic [11:0] sumStep(input logic [11:0] sum, input logic [7:0] b);
    logic [11:0] mixed;
    mixed = ((b & sumMask) != 8'd0) ? (sum ^ sumXor) : sum;
    return mixed + {4'd0, b};                 // wraps at 4096
endfunction

// key byte k comes from stream byte 19-k
function automatic logic [63:0] keyOf(input logic [7:0] bytes [0:keyBytes-1]);
    logic [63:0] key;
    for (int k = 0; k < 8; k++)
        key[8*k +: 8] = bytes[keyBytes-1-k];
    return key;
endfunction

// crypted flag on top of the 16-bit result
function automatic logic [16:0] cipherWord(input logic [15:0] data, input logic [23:0] addr,
                                           input logic [63:0] key, input logic [15:0] limit);
    logic [7:0] l, r, m, f, t;
    if (addr[23:8] > limit)
        return {1'b0, data};                  // above limit, untouched
    l = data[15:8];
    r = data[7:0];
    for (int i = 0; i < numRounds; i++) begin
        m = r ^ key[16*i +: 8];
        f = ({m[6:0], m[7]} + key[16*i+8 +: 8]) ^ addr[7:0];
        t = r;
        r = l ^ f;
        l = t;
    end
    return {1'b1, l, r};
endfunction

function automatic logic slvErrOf(input logic sel, input logic en, input logic wr,
                                  input logic [3:0] addr);
    logic mapped;
    mapped = (addr == 4'h0) || (addr == 4'h4) || (addr == 4'h8) || (addr == 4'hC);
    return sel && en && (!mapped || (wr && addr == 4'h8));
endfunction

function automatic logic [31:0] statusOf(input logic [11:0] sum, input logic [4:0] count,
                                         input logic ok, input logic rdy, input logic flt);
    return {5'd0, flt, rdy, ok, 3'd0, count, 4'd0, sum};
endfunction

`endif

//--- sim/cryptTb.sv
// testbench for the fetch decryption unit
// clock, reset, APB and fetch stimulus from a seeded LCG
// concurrent checks against the reference model, cycle timeout

`timescale 1ns/1ps

module cryptTb import cryptPkg::*; ();

`include "cryptModel.svh"

    logic        clk;
    logic        rst;
    logic        psel, penable, pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    fetchReqT    fetchReq;
    fetchRspT    fetchRsp;
    logic        fetchReady;

    logic [31:0] rngState = 32'd21;             // LCG seed
    logic [7:0]  stream [0:keyBytes-1];         // bytes of the current load
    logic [11:0] modelSum;
    logic [63:0] modelKey;
    logic [15:0] modelLimit;
    logic [5:0]  acceptHist;                    // bit n set n+1 cycles after accept
    logic [16:0] expRsp;                        // crypted above data
    logic [31:0] expRead;
    logic        readChk = 1'b0;
    logic        lockedOut = 1'b0;              // fetch port must stay closed
    int          cycleCount = 0;
    int          timeoutCycles = 3 * 150 + 200 * 7 + 2150;   // loads, fetches, margin

    cryptTop UUT (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .fetchReq, .fetchRsp, .fetchReady
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles)
            failRun("timeout: the run did not finish within the cycle limit");
    end

    // expected response latched at the accepting edge
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            acceptHist <= '0;
            expRsp     <= '0;
        end else begin
            acceptHist <= {acceptHist[4:0], fetchReady && fetchReq.valid};
            if (fetchReady && fetchReq.valid)
                expRsp <= cipherWord(fetchReq.data, fetchReq.addr, modelKey, modelLimit);
        end
    end

    resetState: assert property (@(posedge clk) rst |-> !fetchReady && !fetchRsp.valid && !pslverr)
        else failRun($sformatf("[FAIL] reset fetchReady/valid/pslverr got %h/%h/%h expected 0",
                     $sampled(fetchReady), $sampled(fetchRsp.valid), $sampled(pslverr)));
    apbErr: assert property (@(posedge clk) disable iff (rst)
        pready && pslverr == slvErrOf(psel, penable, pwrite, paddr))
        else failRun($sformatf("[FAIL] pslverr got %h expected %h (pready %h)", $sampled(pslverr),
                     slvErrOf($sampled(psel), $sampled(penable), $sampled(pwrite),
                     $sampled(paddr)), $sampled(pready)));
    statusRead: assert property (@(posedge clk) disable iff (rst)
        (readChk && psel && penable && !pwrite) |-> prdata == expRead)
        else failRun($sformatf("[FAIL] prdata got %h expected %h", $sampled(prdata),
                     $sampled(expRead)));
    rspOnTime: assert property (@(posedge clk) disable iff (rst)
        acceptHist[5] |-> fetchRsp.valid && {fetchRsp.crypted, fetchRsp.data} == expRsp)
        else failRun($sformatf("[FAIL] fetchRsp valid/crypted/data got %h/%h/%h expected 1/%h/%h",
                     $sampled(fetchRsp.valid), $sampled(fetchRsp.crypted),
                     $sampled(fetchRsp.data), $sampled(expRsp[16]), $sampled(expRsp[15:0])));
    rspNoExtra: assert property (@(posedge clk) disable iff (rst) fetchRsp.valid |-> acceptHist[5])
        else failRun("response valid without a request accepted five edges before");
    readyLow: assert property (@(posedge clk) disable iff (rst)
        ((|acceptHist[4:0]) || lockedOut) |-> !fetchReady)
        else failRun($sformatf("[FAIL] fetchReady got %h expected 0", $sampled(fetchReady)));
    readyBack: assert property (@(posedge clk) disable iff (rst) acceptHist[5] |-> fetchReady)
        else failRun($sformatf("[FAIL] fetchReady got %h expected 1", $sampled(fetchReady)));

    function automatic logic [31:0] randWord();
        rngState = lcgStep(rngState);
        return rngState;
    endfunction

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;                        // setup phase
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apbRead(input logic [3:0] addr, input logic [31:0] expVal, input logic chk);
        @(posedge clk);
        psel    <= 1'b1;
        paddr   <= addr;
        expRead <= expVal;
        readChk <= chk;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        readChk <= 1'b0;
    endtask

    // limit high byte kept mid range so both paths occur
    task automatic loadKey(input logic goodSum);
        logic [31:0] r;
        modelSum = 12'd0;
        for (int i = 0; i < keyBytes; i++) begin
            r = randWord();
            stream[i] = (i == 0) ? (8'h40 | (r[23:16] & 8'h3F)) : r[23:16];
            modelSum = sumStep(modelSum, stream[i]);
        end
        modelKey   = keyOf(stream);
        modelLimit = {stream[0], stream[1]};
        apbWrite(regExpSum, {20'd0, goodSum ? modelSum : (modelSum ^ 12'h001)});
        for (int i = 0; i < keyBytes; i++)
            apbWrite(regKeyData, {24'd0, stream[i]});
    endtask

    task automatic waitReady();
        do @(negedge clk); while (!fetchReady);
    endtask

    task automatic fetchWord(input logic inRange);
        logic [31:0] r;
        logic [31:0] d;
        logic [15:0] page;
        r = randWord();
        d = randWord();
        if (inRange)
            page = 16'(r % (32'(modelLimit) + 32'd1));
        else
            page = 16'(32'(modelLimit) + 32'd1 + r % (32'hFFFF - 32'(modelLimit)));
        waitReady();
        @(posedge clk);
        fetchReq <= '{valid: 1'b1, addr: {page, d[7:0]}, data: d[31:16]};
        @(posedge clk);
        fetchReq.valid <= 1'b0;                 // taken at this edge
    endtask

    task automatic holdRequest(input int cycles);
        @(posedge clk);
        fetchReq  <= '{valid: 1'b1, addr: 24'h000010, data: 16'hBEEF};
        lockedOut <= 1'b1;
        repeat (cycles) @(posedge clk);
        fetchReq.valid <= 1'b0;
        lockedOut      <= 1'b0;
    endtask

    initial begin
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 4'h0;
        pwdata   = 32'd0;
        fetchReq = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        apbRead(regStatus, 32'd0, 1'b1);
        apbRead(4'h2, 32'd0, 1'b0);             // unmapped offset
        apbWrite(regStatus, 32'hFFFF_FFFF);     // read only register
        loadKey(1'b1);
        waitReady();
        apbRead(regStatus, statusOf(modelSum, 5'd20, 1'b1, 1'b1, 1'b0), 1'b1);
        for (int i = 0; i < 150; i++)
            fetchWord(i % 2 == 0);
        waitReady();                            // no reload with a word in flight
        apbWrite(regCtrl, 32'd1);
        loadKey(1'b0);
        repeat (3) @(posedge clk);              // sLoad, sCheck, sFault
        apbRead(regStatus, statusOf(modelSum, 5'd20, 1'b0, 1'b0, 1'b1), 1'b1);
        holdRequest(10);
        apbWrite(regCtrl, 32'd1);
        loadKey(1'b1);
        waitReady();
        apbRead(regStatus, statusOf(modelSum, 5'd20, 1'b1, 1'b1, 1'b0), 1'b1);
        for (int i = 0; i < 50; i++)
            fetchWord(i % 2 == 1);
        waitReady();
        repeat (2) @(posedge clk);              // last response checked
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+sim
common/cryptPkg.sv
keyload/keyLoad.sv
hdl/apbRegs.sv
hdl/cryptFsm.sv
hdl/roundCounter.sv
cipher/feistelCore.sv
hdl/cryptTop.sv
sim/cryptTb.sv

//--- Makefile
# Verilator build and run for the fetch decryption unit

VERILATOR ?= verilator
TOP       ?= cryptTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST) sim/cryptModel.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(EXE)
	-./$(EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
